//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := decodeTb
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim.f
src/decodePkg.sv
src/opClassifier.sv
src/operandSelect.sv
src/decodeCtrl.sv
src/uopIssueStage.sv
src/decodeTop.sv
test/decodeTb.sv

//--- src/decodeCtrl.sv
`timescale 1ns/10ps

module decodeCtrl #(
    parameter int CREDITS = 4
) (
    input  logic clk,
    input  logic rstN,
    input  logic instValid,
    input  logic known,
    input  logic isPair,
    input  logic creditReturn,
    output logic instReady,
    output logic load,
    output logic secondHalf,
    output logic uopValid
);

    localparam int CW = $clog2(CREDITS + 1);

    logic [CW-1:0] credits;
    logic          pending;                    // lo half still owed
    logic          spend;

    // no new word while a lo half waits
    assign instReady  = (credits != '0) && !pending;
    assign load       = instValid && instReady && known;
    assign secondHalf = pending && (credits != '0);
    assign spend      = load || secondHalf;    // never both in one cycle

    // =========================================================================
    // credits, pending flag and output valid
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            credits  <= CW'(CREDITS);
            pending  <= 1'b0;
            uopValid <= 1'b0;
        end else begin
            credits  <= credits - CW'(spend) + CW'(creditReturn);
            pending  <= (pending && !secondHalf) || (load && isPair);
            uopValid <= spend;
        end
    end

endmodule

//--- src/decodePkg.sv
package decodePkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  regAddr_t;        // 0..31 gpr, 32 hi, 33 lo

    localparam regAddr_t REG_RA = 6'd31;
    localparam regAddr_t REG_HI = 6'd32;
    localparam regAddr_t REG_LO = 6'd33;

    // one fetched word, read as R fields or as I/J fields
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i;
    } instWord_u;

    // =========================================================================
    // grouped by class, ranges are used by the classifier
    typedef enum logic [5:0] {
        UOP_ADD, UOP_ADDU, UOP_SUB, UOP_SUBU, UOP_SLT, UOP_SLTU,
        UOP_ADDI, UOP_ADDIU, UOP_SLTI, UOP_SLTIU,
        UOP_AND, UOP_OR, UOP_XOR, UOP_NOR, UOP_ANDI, UOP_ORI, UOP_XORI, UOP_LUI,
        UOP_SLL, UOP_SRL, UOP_SRA, UOP_SLLV, UOP_SRLV, UOP_SRAV,
        UOP_BEQ, UOP_BNE, UOP_BGEZ, UOP_BGTZ, UOP_BLEZ, UOP_BLTZ,
        UOP_BGEZAL, UOP_BLTZAL, UOP_J, UOP_JAL, UOP_JR, UOP_JALR,
        UOP_MFHI, UOP_MFLO, UOP_MTHI, UOP_MTLO,
        // each hi kind sits right before its lo partner
        UOP_MULTHI, UOP_MULTLO, UOP_MULTUHI, UOP_MULTULO,
        UOP_DIVHI, UOP_DIVLO, UOP_DIVUHI, UOP_DIVULO,
        UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU, UOP_SB, UOP_SH, UOP_SW
    } uopKind_e;

    typedef enum logic [1:0] {UNIT_ALU, UNIT_MDU, UNIT_LSU} execUnit_e;

    typedef enum logic [2:0] {
        ALU_ARITH, ALU_LOGIC, ALU_SHIFT, ALU_BRANCH, ALU_MOVE, ALU_NONE
    } aluClass_e;

    typedef enum logic [2:0] {
        SEL_NONE, SEL_RS, SEL_RT, SEL_RD, SEL_HI, SEL_LO, SEL_RA
    } regSel_e;

    typedef enum logic [1:0] {IMM_SIGN, IMM_ZERO, IMM_UPPER, IMM_SHAMT} immSel_e;

    typedef enum logic [1:0] {TGT_NONE, TGT_BRANCH, TGT_JUMP} targetSel_e;

endpackage

//--- src/decodeTop.sv
`timescale 1ns/10ps

module decodeTop import decodePkg::*; #(
    parameter int CREDITS = 4
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        instValid,
    input  instWord_u   instWord,
    input  word_t       instPc,
    input  logic        creditReturn,
    output logic        instReady,
    output logic        uopValid,
    output uopKind_e    uopKind,
    output execUnit_e   uopUnit,
    output aluClass_e   uopAluClass,
    output regAddr_t    uopOp0Addr,
    output regAddr_t    uopOp1Addr,
    output regAddr_t    uopDstAddr,
    output logic        uopOp0Re,
    output logic        uopOp1Re,
    output logic        uopDstWe,
    output word_t       uopImm,
    output word_t       uopTarget,
    output word_t       uopPc
);

    uopKind_e    kind;
    execUnit_e   unit;
    aluClass_e   aluClass;
    regSel_e     op0Sel;
    regSel_e     op1Sel;
    regSel_e     dstSel;
    immSel_e     immSel;
    targetSel_e  targetSel;
    logic        isPair;
    logic        known;
    regAddr_t    op0Addr;
    regAddr_t    op1Addr;
    regAddr_t    dstAddr;
    logic        op0Re;
    logic        op1Re;
    logic        dstWe;
    word_t       imm;
    word_t       target;
    logic        load;
    logic        secondHalf;

    opClassifier classifier (
        .instWord(instWord), .kind(kind), .unit(unit), .aluClass(aluClass),
        .op0Sel(op0Sel), .op1Sel(op1Sel), .dstSel(dstSel), .immSel(immSel),
        .targetSel(targetSel), .isPair(isPair), .known(known)
    );

    operandSelect operands (
        .instWord(instWord), .instPc(instPc), .op0Sel(op0Sel), .op1Sel(op1Sel),
        .dstSel(dstSel), .immSel(immSel), .targetSel(targetSel),
        .op0Addr(op0Addr), .op1Addr(op1Addr), .dstAddr(dstAddr),
        .op0Re(op0Re), .op1Re(op1Re), .dstWe(dstWe), .imm(imm), .target(target)
    );

    decodeCtrl #(.CREDITS(CREDITS)) ctrl (
        .clk(clk), .rstN(rstN), .instValid(instValid), .known(known),
        .isPair(isPair), .creditReturn(creditReturn), .instReady(instReady),
        .load(load), .secondHalf(secondHalf), .uopValid(uopValid)
    );

    uopIssueStage issue (
        .clk(clk), .rstN(rstN), .load(load), .secondHalf(secondHalf),
        .kind(kind), .unit(unit), .aluClass(aluClass),
        .op0Addr(op0Addr), .op1Addr(op1Addr), .dstAddr(dstAddr),
        .op0Re(op0Re), .op1Re(op1Re), .dstWe(dstWe),
        .imm(imm), .target(target), .instPc(instPc),
        .uopKind(uopKind), .uopUnit(uopUnit), .uopAluClass(uopAluClass),
        .uopOp0Addr(uopOp0Addr), .uopOp1Addr(uopOp1Addr), .uopDstAddr(uopDstAddr),
        .uopOp0Re(uopOp0Re), .uopOp1Re(uopOp1Re), .uopDstWe(uopDstWe),
        .uopImm(uopImm), .uopTarget(uopTarget), .uopPc(uopPc)
    );

endmodule

//--- src/opClassifier.sv
`timescale 1ns/10ps

module opClassifier import decodePkg::*; (
    input  instWord_u   instWord,
    output uopKind_e    kind,
    output execUnit_e   unit,
    output aluClass_e   aluClass,
    output regSel_e     op0Sel,
    output regSel_e     op1Sel,
    output regSel_e     dstSel,
    output immSel_e     immSel,
    output targetSel_e  targetSel,
    output logic        isPair,
    output logic        known
);

    // =========================================================================
    // opcode, funct and regimm rt match
    always_comb begin
        kind  = UOP_ADD;
        known = 1'b1;
        case (instWord.i.opcode)
            6'h00:
                case (instWord.r.funct)
                    6'h00:   kind = UOP_SLL;
                    6'h02:   kind = UOP_SRL;
                    6'h03:   kind = UOP_SRA;
                    6'h04:   kind = UOP_SLLV;
                    6'h06:   kind = UOP_SRLV;
                    6'h07:   kind = UOP_SRAV;
                    6'h08:   kind = UOP_JR;
                    6'h09:   kind = UOP_JALR;
                    6'h10:   kind = UOP_MFHI;
                    6'h11:   kind = UOP_MTHI;
                    6'h12:   kind = UOP_MFLO;
                    6'h13:   kind = UOP_MTLO;
                    6'h18:   kind = UOP_MULTHI;
                    6'h19:   kind = UOP_MULTUHI;
                    6'h1a:   kind = UOP_DIVHI;
                    6'h1b:   kind = UOP_DIVUHI;
                    6'h20:   kind = UOP_ADD;
                    6'h21:   kind = UOP_ADDU;
                    6'h22:   kind = UOP_SUB;
                    6'h23:   kind = UOP_SUBU;
                    6'h24:   kind = UOP_AND;
                    6'h25:   kind = UOP_OR;
                    6'h26:   kind = UOP_XOR;
                    6'h27:   kind = UOP_NOR;
                    6'h2a:   kind = UOP_SLT;
                    6'h2b:   kind = UOP_SLTU;
                    default: known = 1'b0;
                endcase
            6'h01:                                      // regimm, rt picks the branch
                case (instWord.i.rt)
                    5'h00:   kind = UOP_BLTZ;
                    5'h01:   kind = UOP_BGEZ;
                    5'h10:   kind = UOP_BLTZAL;
                    5'h11:   kind = UOP_BGEZAL;
                    default: known = 1'b0;
                endcase
            6'h02:   kind = UOP_J;
            6'h03:   kind = UOP_JAL;
            6'h04:   kind = UOP_BEQ;
            6'h05:   kind = UOP_BNE;
            6'h06:   kind = UOP_BLEZ;
            6'h07:   kind = UOP_BGTZ;
            6'h08:   kind = UOP_ADDI;
            6'h09:   kind = UOP_ADDIU;
            6'h0a:   kind = UOP_SLTI;
            6'h0b:   kind = UOP_SLTIU;
            6'h0c:   kind = UOP_ANDI;
            6'h0d:   kind = UOP_ORI;
            6'h0e:   kind = UOP_XORI;
            6'h0f:   kind = UOP_LUI;
            6'h20:   kind = UOP_LB;
            6'h21:   kind = UOP_LH;
            6'h23:   kind = UOP_LW;
            6'h24:   kind = UOP_LBU;
            6'h25:   kind = UOP_LHU;
            6'h28:   kind = UOP_SB;
            6'h29:   kind = UOP_SH;
            6'h2b:   kind = UOP_SW;
            default: known = 1'b0;
        endcase
        if (instWord == '0) begin
            known = 1'b0;                               // nop wins over sll
        end
    end

    // =========================================================================
    // operand sources per kind
    always_comb begin
        case (kind) inside
            [UOP_MULTHI:UOP_DIVULO]: unit = UNIT_MDU;
            [UOP_LB:UOP_SW]:         unit = UNIT_LSU;
            default:                 unit = UNIT_ALU;
        endcase
        case (kind) inside
            [UOP_ADD:UOP_SLTIU]:     aluClass = ALU_ARITH;
            [UOP_AND:UOP_LUI]:       aluClass = ALU_LOGIC;
            [UOP_SLL:UOP_SRAV]:      aluClass = ALU_SHIFT;
            [UOP_BEQ:UOP_JALR]:      aluClass = ALU_BRANCH;
            [UOP_MFHI:UOP_MTLO]:     aluClass = ALU_MOVE;
            default:                 aluClass = ALU_NONE;
        endcase
        case (kind)
            UOP_SLL, UOP_SRL, UOP_SRA,
            UOP_SLLV, UOP_SRLV, UOP_SRAV: op0Sel = SEL_RT;    // shifted value
            UOP_MFHI:                     op0Sel = SEL_HI;
            UOP_MFLO:                     op0Sel = SEL_LO;
            UOP_J, UOP_JAL:               op0Sel = SEL_NONE;
            default:                      op0Sel = SEL_RS;
        endcase
        case (kind)
            UOP_ADD, UOP_ADDU, UOP_SUB, UOP_SUBU, UOP_SLT, UOP_SLTU,
            UOP_AND, UOP_OR, UOP_XOR, UOP_NOR, UOP_BEQ, UOP_BNE,
            UOP_MULTHI, UOP_MULTUHI, UOP_DIVHI, UOP_DIVUHI,
            UOP_SB, UOP_SH, UOP_SW:       op1Sel = SEL_RT;
            UOP_SLLV, UOP_SRLV, UOP_SRAV: op1Sel = SEL_RS;    // shift amount
            default:                      op1Sel = SEL_NONE;
        endcase
        case (kind)
            UOP_ADDI, UOP_ADDIU, UOP_SLTI, UOP_SLTIU, UOP_ANDI, UOP_ORI, UOP_XORI,
            UOP_LUI, UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU: dstSel = SEL_RT;
            UOP_BGEZAL, UOP_BLTZAL, UOP_JAL:                   dstSel = SEL_RA;
            UOP_MTHI, UOP_MULTHI, UOP_MULTUHI,
            UOP_DIVHI, UOP_DIVUHI:                             dstSel = SEL_HI;
            UOP_MTLO:                                          dstSel = SEL_LO;
            UOP_BEQ, UOP_BNE, UOP_BGEZ, UOP_BGTZ, UOP_BLEZ, UOP_BLTZ,
            UOP_J, UOP_JR, UOP_SB, UOP_SH, UOP_SW:             dstSel = SEL_NONE;
            default:                                           dstSel = SEL_RD;
        endcase
        case (kind)
            UOP_ANDI, UOP_ORI, UOP_XORI: immSel = IMM_ZERO;
            UOP_LUI:                     immSel = IMM_UPPER;
            UOP_SLL, UOP_SRL, UOP_SRA:   immSel = IMM_SHAMT;
            default:                     immSel = IMM_SIGN;
        endcase
        case (kind)
            UOP_BEQ, UOP_BNE, UOP_BGEZ, UOP_BGTZ, UOP_BLEZ, UOP_BLTZ,
            UOP_BGEZAL, UOP_BLTZAL:      targetSel = TGT_BRANCH;
            UOP_J, UOP_JAL:              targetSel = TGT_JUMP;
            default:                     targetSel = TGT_NONE;
        endcase
        isPair = kind inside {UOP_MULTHI, UOP_MULTUHI, UOP_DIVHI, UOP_DIVUHI};
    end

endmodule

//--- src/operandSelect.sv
`timescale 1ns/10ps

module operandSelect import decodePkg::*; (
    input  instWord_u   instWord,
    input  word_t       instPc,
    input  regSel_e     op0Sel,
    input  regSel_e     op1Sel,
    input  regSel_e     dstSel,
    input  immSel_e     immSel,
    input  targetSel_e  targetSel,
    output regAddr_t    op0Addr,
    output regAddr_t    op1Addr,
    output regAddr_t    dstAddr,
    output logic        op0Re,
    output logic        op1Re,
    output logic        dstWe,
    output word_t       imm,
    output word_t       target
);

    logic [15:0] imm16;
    logic [25:0] jumpIndex;

    function automatic regAddr_t selAddr(regSel_e sel, instWord_u w);
        case (sel)
            SEL_RS:  return {1'b0, w.r.rs};
            SEL_RT:  return {1'b0, w.r.rt};
            SEL_RD:  return {1'b0, w.r.rd};
            SEL_HI:  return REG_HI;
            SEL_LO:  return REG_LO;
            SEL_RA:  return REG_RA;
            default: return '0;
        endcase
    endfunction

    assign imm16     = instWord.i.imm16;
    assign jumpIndex = {instWord.i.rs, instWord.i.rt, instWord.i.imm16};

    assign op0Addr = selAddr(op0Sel, instWord);
    assign op1Addr = selAddr(op1Sel, instWord);
    assign dstAddr = selAddr(dstSel, instWord);
    assign op0Re   = (op0Sel != SEL_NONE);
    assign op1Re   = (op1Sel != SEL_NONE);
    assign dstWe   = (dstSel != SEL_NONE);

    always_comb begin
        case (immSel)
            IMM_ZERO:  imm = {16'h0000, imm16};
            IMM_UPPER: imm = {imm16, 16'h0000};                     // lui
            IMM_SHAMT: imm = {27'd0, instWord.r.shamt};
            default:   imm = {{16{imm16[15]}}, imm16};
        endcase
        case (targetSel)
            TGT_BRANCH: target = {{14{imm16[15]}}, imm16, 2'b00};   // pc-relative offset
            TGT_JUMP:   target = {instPc[31:28], jumpIndex, 2'b00}; // region from pc
            default:    target = '0;
        endcase
    end

endmodule

//--- src/uopIssueStage.sv
`timescale 1ns/10ps

module uopIssueStage import decodePkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        load,
    input  logic        secondHalf,
    input  uopKind_e    kind,
    input  execUnit_e   unit,
    input  aluClass_e   aluClass,
    input  regAddr_t    op0Addr,
    input  regAddr_t    op1Addr,
    input  regAddr_t    dstAddr,
    input  logic        op0Re,
    input  logic        op1Re,
    input  logic        dstWe,
    input  word_t       imm,
    input  word_t       target,
    input  word_t       instPc,
    output uopKind_e    uopKind,
    output execUnit_e   uopUnit,
    output aluClass_e   uopAluClass,
    output regAddr_t    uopOp0Addr,
    output regAddr_t    uopOp1Addr,
    output regAddr_t    uopDstAddr,
    output logic        uopOp0Re,
    output logic        uopOp1Re,
    output logic        uopDstWe,
    output word_t       uopImm,
    output word_t       uopTarget,
    output word_t       uopPc
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            uopOp0Re <= 1'b0;
            uopOp1Re <= 1'b0;
            uopDstWe <= 1'b0;
        end else if (load) begin
            uopOp0Re <= op0Re;
            uopOp1Re <= op1Re;
            uopDstWe <= dstWe;                  // lo half keeps the write
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            uopKind     <= kind;
            uopUnit     <= unit;
            uopAluClass <= aluClass;
            uopOp0Addr  <= op0Addr;
            uopOp1Addr  <= op1Addr;
            uopDstAddr  <= dstAddr;
            uopImm      <= imm;
            uopTarget   <= target;
            uopPc       <= instPc;
        end else if (secondHalf) begin
            uopKind    <= uopKind_e'(uopKind + 6'd1);   // hi kind to its lo partner
            uopDstAddr <= REG_LO;
        end
    end

endmodule

//--- test/decodeTb.sv
`timescale 1ns/10ps

module decodeTb import decodePkg::*; ();

    localparam int    CREDITS        = 4;
    localparam int    CYCLES_PER_REC = 40;
    localparam string DATA_FILE      = "test/decode_testdata.txt";

    logic         clk;
    logic         rstN;
    logic         instValid;
    instWord_u    instWord;
    word_t        instPc;
    logic         creditReturn = 1'b0;
    logic         instReady;
    logic         uopValid;
    uopKind_e     uopKind;
    execUnit_e    uopUnit;
    aluClass_e    uopAluClass;
    regAddr_t     uopOp0Addr;
    regAddr_t     uopOp1Addr;
    regAddr_t     uopDstAddr;
    logic         uopOp0Re;
    logic         uopOp1Re;
    logic         uopDstWe;
    word_t        uopImm;
    word_t        uopTarget;
    word_t        uopPc;

    word_t        words [$];
    word_t        pcs [$];
    logic [127:0] expQ [$];             // pc and kind to target in program order
    int           delays [$];           // cycles until each credit goes back
    int           owed;
    int           outstanding;
    int           checked;
    int           errors;
    int           loadErrors;
    logic [31:0]  rngState = 32'h45d1;

    decodeTop #(.CREDITS(CREDITS)) uut (
        .clk(clk), .rstN(rstN), .instValid(instValid), .instWord(instWord),
        .instPc(instPc), .creditReturn(creditReturn), .instReady(instReady),
        .uopValid(uopValid), .uopKind(uopKind), .uopUnit(uopUnit),
        .uopAluClass(uopAluClass), .uopOp0Addr(uopOp0Addr), .uopOp1Addr(uopOp1Addr),
        .uopDstAddr(uopDstAddr), .uopOp0Re(uopOp0Re), .uopOp1Re(uopOp1Re),
        .uopDstWe(uopDstWe), .uopImm(uopImm), .uopTarget(uopTarget), .uopPc(uopPc)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        assert (got === want) else begin
            $display("mismatch %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    // ========================================================================
    // i lines hold an instruction and u lines its expected micro-ops
    task automatic loadRecords();
        int          fd;
        int          got;
        int          n;
        int          left;
        string       line;
        word_t       w;
        word_t       pc;
        logic [31:0] f [11];
        left = 0;
        pc   = '0;
        fd   = $fopen(DATA_FILE, "r");
        assert (fd != 0) else begin
            $display("could not open the data file %s", DATA_FILE);
            loadErrors++;
        end
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if (line.getc(0) == "i") begin
                got = $sscanf(line, "i %h %h %d", w, pc, n);
                assert (got == 3 && left == 0) else begin
                    $display("bad instruction line or missing micro-ops before: %s", line);
                    loadErrors++;
                end
                words.push_back(w);
                pcs.push_back(pc);
                left = n;
            end else begin
                got = $sscanf(line, "u %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                              f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                assert (got == 11 && left > 0) else begin
                    $display("bad or unexpected micro-op line: %s", line);
                    loadErrors++;
                end
                expQ.push_back({pc, f[0][5:0], f[1][1:0], f[2][2:0], f[3][5:0], f[4][5:0],
                                f[5][5:0], f[6][0], f[7][0], f[8][0], f[9], f[10]});
                left--;
            end
        end
        $fclose(fd);
        assert (words.size() != 0 && left == 0) else begin
            $display("data file is empty or its last record is short");
            loadErrors++;
        end
    endtask

    task automatic reportAndFinish(input logic timedOut);
        int total;
        total = errors + loadErrors + int'(timedOut);
        $display("checked %0d micro-ops, %0d errors, %0d still expected",
                 checked, total, expQ.size());
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================================================
    // driver
    initial begin
        rstN      = 1'b0;
        instValid = 1'b0;
        instWord  = '0;
        instPc    = '0;
        loadRecords();
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        foreach (words[i]) begin
            instValid <= 1'b1;
            instWord  <= words[i];
            instPc    <= pcs[i];
            do begin
                @(posedge clk);
            end while (!instReady);             // accepted on this edge
        end
        instValid <= 1'b0;
        do begin
            @(negedge clk);
        end while (expQ.size() != 0 || outstanding != 0);
        @(posedge clk);                         // last credit pulse counted here
        @(negedge clk);
        checkField("instReady", 32'(instReady), 32'd1);
        checkField("uopValid", 32'(uopValid), 32'd0);
        reportAndFinish(1'b0);
    end

    // receiver, checker and credit return
    always @(posedge clk) begin
        logic [127:0] want;
        int           keep [$];
        if (rstN && uopValid) begin
            assert (expQ.size() != 0) else begin
                $display("micro-op of kind %h issued with nothing left to expect", uopKind);
                errors++;
            end
            if (expQ.size() != 0) begin
                want = expQ.pop_front();
                checkField("uopPc", uopPc, want[127:96]);
                checkField("uopKind", 32'(uopKind), 32'(want[95:90]));
                checkField("uopUnit", 32'(uopUnit), 32'(want[89:88]));
                checkField("uopAluClass", 32'(uopAluClass), 32'(want[87:85]));
                checkField("uopOp0Addr", 32'(uopOp0Addr), 32'(want[84:79]));
                checkField("uopOp1Addr", 32'(uopOp1Addr), 32'(want[78:73]));
                checkField("uopDstAddr", 32'(uopDstAddr), 32'(want[72:67]));
                checkField("uopOp0Re", 32'(uopOp0Re), 32'(want[66]));
                checkField("uopOp1Re", 32'(uopOp1Re), 32'(want[65]));
                checkField("uopDstWe", 32'(uopDstWe), 32'(want[64]));
                checkField("uopImm", uopImm, want[63:32]);
                checkField("uopTarget", uopTarget, want[31:0]);
                checked++;
            end
            rngState = xorshift(rngState);
            delays.push_back(int'(rngState % 32'd6));
            outstanding++;
            assert (outstanding <= CREDITS) else begin
                $display("more than %0d micro-ops outstanding at the receiver", CREDITS);
                errors++;
            end
        end
        keep = {};
        foreach (delays[i]) begin
            if (delays[i] == 0) begin
                owed++;
            end else begin
                keep.push_back(delays[i] - 1);
            end
        end
        delays = keep;
        if (owed > 0) begin                     // one slot freed per pulse
            creditReturn <= 1'b1;
            owed--;
            outstanding--;
        end else begin
            creditReturn <= 1'b0;
        end
    end

    initial begin
        int limit;
        #1;
        limit = words.size() * CYCLES_PER_REC;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles with %0d micro-ops never seen", limit, expQ.size());
        reportAndFinish(1'b1);
    end

endmodule

//--- test/decode_testdata.txt
# i <word> <pc> <micro-op count>
# u <kind> <unit> <aluClass> <op0> <op1> <dst> <op0Re> <op1Re> <dstWe> <imm> <target>
i 00221820 00400000 1
u 00 0 0 01 02 03 1 1 1 00001820 00000000
i 2085fffd 00400004 1
u 06 0 0 04 00 05 1 0 1 fffffffd 00000000
i 34c78001 00400008 1
u 0f 0 1 06 00 07 1 0 1 00008001 00000000
i 3c0abeef 0040000c 1
u 11 0 1 00 00 0a 1 0 1 beef0000 00000000
i 00000000 00400010 0
i 018d5827 00400014 1
u 0d 0 1 0c 0d 0b 1 1 1 00005827 00000000
i 00118140 00400018 1
u 12 0 2 11 00 10 1 0 1 00000005 00000000
i 02d5a006 0040001c 1
u 16 0 2 15 16 14 1 1 1 ffffa006 00000000
i 00850018 00400020 2
u 28 1 5 04 05 20 1 1 1 00000018 00000000
u 29 1 5 04 05 21 1 1 1 00000018 00000000
i 00c7001b 00400024 2
u 2e 1 5 06 07 20 1 1 1 0000001b 00000000
u 2f 1 5 06 07 21 1 1 1 0000001b 00000000
i 0109001a 00400028 2
u 2c 1 5 08 09 20 1 1 1 0000001a 00000000
u 2d 1 5 08 09 21 1 1 1 0000001a 00000000
i 00004010 0040002c 1
u 24 0 4 20 00 08 1 0 1 00004010 00000000
i 00002012 00400030 1
u 25 0 4 21 00 04 1 0 1 00002012 00000000
i 1022fffc 00400034 1
u 18 0 3 01 02 00 1 1 0 fffffffc fffffff0
i 04710010 00400038 1
u 1e 0 3 03 00 1f 1 0 1 00000010 00000040
i fc001234 0040003c 0
i 08123456 a0400040 1
u 20 0 3 00 00 00 0 0 0 00003456 a048d158
i 0fffffff bfc00044 1
u 21 0 3 00 00 1f 0 0 1 ffffffff bffffffc
i 03e00008 00400048 1
u 22 0 3 1f 00 00 1 0 0 00000008 00000000
i 0320f009 0040004c 1
u 23 0 3 19 00 1e 1 0 1 fffff009 00000000
i 00600011 00400050 1
u 26 0 4 03 00 20 1 0 1 00000011 00000000
i 01200013 00400054 1
u 27 0 4 09 00 21 1 0 1 00000013 00000000
i 8faafff8 00400058 1
u 32 2 5 1d 00 0a 1 0 1 fffffff8 00000000
i a18b0003 0040005c 1
u 35 2 5 0c 0b 00 1 1 0 00000003 00000000
